//--- design/board_pkg.sv
// Board constants
// clock rate, default serial rate and start-up delay size

package board_pkg;

    localparam int clk_freq  = 48_000_000;  // Hz
    localparam int baud_rate = 460_800;     // power-up serial rate

    // cycles per bit at power-up, 104 at 48 MHz
    localparam logic [7:0] default_divisor = 8'(clk_freq / baud_rate);

    // start-up counter width, 2**6 = 64 cycles
    localparam int startup_bits = 6;

endpackage

//--- design/board_top.sv
// Board wrapper
// start-up delay after reset gating the bus, UART core and status LEDs

`timescale 1ns/1ns

module board_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,         // serial in
    output logic       tx,         // serial out
    input  logic       bus_en,
    input  logic       bus_wr,
    input  logic [3:0] bus_addr,
    input  logic [7:0] bus_wdata,
    output logic [7:0] bus_rdata,
    output logic       led_r,
    output logic       led_g,
    output logic       led_b
);

    logic                              run;      // start-up done
    logic [board_pkg::startup_bits-1:0] waiting;  // start-up count

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run     <= 1'b0;
            waiting <= '0;
        end else if (!run) begin
            {run, waiting} <= {1'b0, waiting} + 1'b1;  // carry out sets run
        end
    end

    uart uart0 (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .en    (bus_en && run),  // bus ignored during start-up
        .wr    (bus_wr),
        .addr  (bus_addr),
        .wdata (bus_wdata),
        .tx    (tx),
        .rdata (bus_rdata)
    );

    assign led_r = !tx;  // lit while sending a zero
    assign led_g = !rx;
    assign led_b = run;

endmodule

//--- design/uart.sv
// UART core
// register bank driving an 8N1 transmitter and receiver

`timescale 1ns/1ns

module uart (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    input  logic       en,
    input  logic       wr,
    input  logic [3:0] addr,
    input  logic [7:0] wdata,
    output logic       tx,
    output logic [7:0] rdata
);

    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;
    logic [7:0] divisor;   // shared bit period
    logic       rx_done;
    logic [7:0] rx_byte;

    uart_regs regs0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .wr       (wr),
        .addr     (addr),
        .wdata    (wdata),
        .tx_busy  (tx_busy),
        .rx_done  (rx_done),
        .rx_byte  (rx_byte),
        .rdata    (rdata),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .divisor  (divisor)
    );

    uart_tx tx0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .divisor  (divisor),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    uart_rx rx0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .divisor  (divisor),
        .rx_done  (rx_done),
        .rx_byte  (rx_byte)
    );

endmodule

//--- design/uart_pkg.sv
// UART register map and frame constants
// addresses, status bit positions and 8N1 frame sizes shared by the core

package uart_pkg;

    // register map, 4-bit bus address
    localparam logic [3:0] addr_data    = 4'd0;  // wr sends byte, rd pops rx buffer
    localparam logic [3:0] addr_status  = 4'd1;  // rd clears overrun
    localparam logic [3:0] addr_divisor = 4'd2;  // clock cycles per bit

    // status byte bit positions
    localparam int status_tx_busy  = 0;
    localparam int status_rx_valid = 1;
    localparam int status_overrun  = 2;

    // 8N1 frame
    localparam int data_bits  = 8;
    localparam int frame_bits = data_bits + 2;  // start + data + stop

    localparam logic [7:0] min_divisor = 8'd4;  // floor for divisor writes

endpackage

//--- design/uart_regs.sv
// UART register bank
// decodes en/wr/addr strobes into tx start, divisor, rx buffer and status,
// read data registered one cycle after the access

`timescale 1ns/1ns

module uart_regs (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic       wr,
    input  logic [3:0] addr,
    input  logic [7:0] wdata,
    input  logic       tx_busy,
    input  logic       rx_done,
    input  logic [7:0] rx_byte,
    output logic [7:0] rdata,
    output logic       tx_start,
    output logic [7:0] tx_byte,
    output logic [7:0] divisor
);

    logic [7:0] rx_buf;
    logic       rx_valid;
    logic       overrun;
    logic [7:0] status;
    logic       data_rd;
    logic       status_rd;

    assign data_rd   = en && !wr && addr == uart_pkg::addr_data;
    assign status_rd = en && !wr && addr == uart_pkg::addr_status;
    assign tx_start  = en && wr && addr == uart_pkg::addr_data && !tx_busy;  // busy drops it
    assign tx_byte   = wdata;

    always_comb begin
        status                           = 8'd0;
        status[uart_pkg::status_tx_busy]  = tx_busy;
        status[uart_pkg::status_rx_valid] = rx_valid;
        status[uart_pkg::status_overrun]  = overrun;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            divisor  <= board_pkg::default_divisor;
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
            rdata    <= 8'd0;
        end else begin
            if (en && wr && addr == uart_pkg::addr_divisor) begin
                divisor <= (wdata < uart_pkg::min_divisor) ? uart_pkg::min_divisor : wdata;
            end
            if (en && !wr) begin
                case (addr)
                    uart_pkg::addr_data:    rdata <= rx_buf;
                    uart_pkg::addr_status:  rdata <= status;
                    uart_pkg::addr_divisor: rdata <= divisor;
                    default:                rdata <= 8'd0;  // unmapped
                endcase
            end
            if (rx_done) rx_valid <= 1'b1;  // new byte beats a same-cycle read
            else if (data_rd) rx_valid <= 1'b0;
            if (rx_done && rx_valid && !data_rd) overrun <= 1'b1;  // old byte lost
            else if (status_rd) overrun <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_done) rx_buf <= rx_byte;
    end

endmodule

//--- design/uart_rx.sv
// UART receiver
// two-flop synchronizer, falling-edge start detect with mid-bit
// confirmation, eight data samples at full periods and a stop check

`timescale 1ns/1ns

module uart_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,       // async serial in
    input  logic [7:0] divisor,  // cycles per bit
    output logic       rx_done,  // one-cycle pulse, byte valid
    output logic [7:0] rx_byte
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_t;

    rx_state_t  state;
    logic       rx_meta;   // first sync stage
    logic       rx_sync;   // second sync stage
    logic       rx_last;   // for edge detect
    logic [7:0] div_q;
    logic [7:0] cnt;
    logic [2:0] bit_idx;
    logic [7:0] shreg;
    logic       fall;
    logic       half_end;
    logic       full_end;

    assign fall     = rx_last && !rx_sync;
    assign half_end = (cnt == (div_q >> 1) - 8'd1);  // middle of start bit
    assign full_end = (cnt == div_q - 8'd1);
    assign rx_byte  = shreg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
            state   <= st_idle;
            cnt     <= 8'd0;
            bit_idx <= 3'd0;
            rx_done <= 1'b0;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
            rx_done <= 1'b0;
            case (state)
                st_idle: begin
                    cnt     <= 8'd0;
                    bit_idx <= 3'd0;
                    if (fall) state <= st_start;
                end
                st_start: begin
                    if (half_end) begin
                        cnt   <= 8'd0;
                        state <= rx_sync ? st_idle : st_data;  // high here is a glitch
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                st_data: begin
                    if (full_end) begin
                        cnt     <= 8'd0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'(uart_pkg::data_bits - 1)) state <= st_stop;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                default: begin  // st_stop
                    if (full_end) begin
                        cnt     <= 8'd0;
                        rx_done <= rx_sync;  // framing error drops the byte
                        state   <= st_idle;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && fall) div_q <= divisor;  // fixed for the frame
        if (state == st_data && full_end) shreg <= {rx_sync, shreg[7:1]};  // lsb first
    end

endmodule

//--- design/uart_tx.sv
// UART transmitter
// 8N1 serializer, start bit then data LSB first then stop bit,
// bit length taken from the divisor latched at start

`timescale 1ns/1ns

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,  // one-cycle request
    input  logic [7:0] tx_byte,
    input  logic [7:0] divisor,   // cycles per bit
    output logic       tx,
    output logic       tx_busy
);

    logic [7:0] shreg;    // data bits still to go
    logic [7:0] div_q;    // divisor held for the frame
    logic [7:0] cnt;      // cycles into current bit
    logic [3:0] bit_idx;  // 0 start, 1..8 data, 9 stop
    logic       bit_end;

    assign bit_end = (cnt == div_q - 8'd1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx      <= 1'b1;  // line idles high
            tx_busy <= 1'b0;
            cnt     <= 8'd0;
            bit_idx <= 4'd0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx      <= 1'b0;  // start bit from next cycle
                tx_busy <= 1'b1;
                cnt     <= 8'd0;
                bit_idx <= 4'd0;
            end
        end else if (bit_end) begin
            cnt <= 8'd0;
            if (bit_idx == 4'(uart_pkg::frame_bits - 1)) begin
                tx_busy <= 1'b0;  // stop bit done, tx already high
            end else begin
                bit_idx <= bit_idx + 4'd1;
                tx      <= (bit_idx < 4'(uart_pkg::data_bits)) ? shreg[0] : 1'b1;
            end
        end else begin
            cnt <= cnt + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_start && !tx_busy) begin
            shreg <= tx_byte;
            div_q <= divisor;
        end else if (tx_busy && bit_end && bit_idx < 4'(uart_pkg::data_bits)) begin
            shreg <= shreg >> 1;  // next data bit into lsb
        end
    end

endmodule

//--- filelist.f
design/uart_pkg.sv
design/board_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/uart.sv
design/board_top.sv
verif/uart_checker.sv
verif/tb_top.sv

//--- run.sh
#!/bin/sh
# build and run the UART testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_top +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- verif/tb_top.sv
// UART board testbench
// start-up gating, transmit, loopback receive, overrun and divisor cases,
// with a tx frame monitor, LED checks and a watchdog

`timescale 1ns/1ns

module tb_top;

    localparam int startup_cycles  = 2 ** board_pkg::startup_bits;
    localparam int watchdog_cycles =
        12 * uart_pkg::frame_bits * int'(board_pkg::default_divisor) + startup_cycles + 5;

    logic       clk;
    logic       rst_n;
    logic       rx;
    logic       tx;
    logic       rx_drv;     // rx when not looped back
    logic       loopback;
    logic       bus_en;
    logic       bus_wr;
    logic [3:0] bus_addr;
    logic [7:0] bus_wdata;
    logic [7:0] bus_rdata;
    logic       led_r;
    logic       led_g;
    logic       led_b;
    logic       run_seen = 1'b0;  // start-up window over
    logic [7:0] exp_q[$];   // bytes expected on tx
    int         frames_seen = 0;
    int         bit_cycles;  // divisor the monitor and rx driver use
    int         seed = 78;

    assign rx = loopback ? tx : rx_drv;

    board_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        assert (got === exp)
        else stop_run($sformatf("ERR %s got 0x%02h expected 0x%02h", name, got, exp));
    endtask

    task automatic bus_write(input logic [3:0] a, input logic [7:0] d);
        bus_en    = 1'b1;
        bus_wr    = 1'b1;
        bus_addr  = a;
        bus_wdata = d;
        @(negedge clk);
        bus_en    = 1'b0;
        bus_wr    = 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] a, output logic [7:0] d);
        bus_en   = 1'b1;
        bus_wr   = 1'b0;
        bus_addr = a;
        @(negedge clk);
        bus_en   = 1'b0;
        d        = bus_rdata;  // value registered by the read
    endtask

    task automatic wait_status(input int bit_pos, input logic level);
        logic [7:0] s;
        bus_read(uart_pkg::addr_status, s);
        while (s[bit_pos] !== level) bus_read(uart_pkg::addr_status, s);
    endtask

    task automatic send_frame(input logic [7:0] data);
        rx_drv = 1'b0;  // start
        repeat (bit_cycles) @(negedge clk);
        for (int i = 0; i < uart_pkg::data_bits; i++) begin
            rx_drv = data[i];
            repeat (bit_cycles) @(negedge clk);
        end
        rx_drv = 1'b1;  // stop
        repeat (bit_cycles) @(negedge clk);
    endtask

    initial begin : stimulus
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] rd;
        int         n;
        bit_cycles = board_pkg::default_divisor;
        {loopback, bus_en, bus_wr, bus_addr, bus_wdata} = '0;
        rx_drv     = 1'b1;
        rst_n      = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        n = 0;
        while (led_b !== 1'b1 && n <= startup_cycles) begin
            bus_en    = (n == 10);  // write inside start-up window
            bus_wr    = 1'b1;
            bus_addr  = uart_pkg::addr_data;
            bus_wdata = 8'h5a;
            @(negedge clk);
            n++;
            check_value("tx", {7'd0, tx}, 8'h01);
        end
        {bus_en, bus_wr} = 2'b00;
        check_value("start-up cycles", 8'(n), 8'(startup_cycles));
        run_seen = 1'b1;
        bus_read(uart_pkg::addr_status, rd);
        check_value("status", rd, 8'h00);
        b1 = 8'($random(seed));
        bus_write(uart_pkg::addr_data, b1);
        exp_q.push_back(b1);
        bus_read(uart_pkg::addr_status, rd);
        check_value("status", rd, 8'(1 << uart_pkg::status_tx_busy));
        bus_write(uart_pkg::addr_data, ~b1);  // dropped while busy
        wait_status(uart_pkg::status_tx_busy, 1'b0);
        check_value("frames seen", 8'(frames_seen), 8'd1);
        loopback = 1'b1;
        b1 = 8'($random(seed));
        bus_write(uart_pkg::addr_data, b1);
        exp_q.push_back(b1);
        wait_status(uart_pkg::status_rx_valid, 1'b1);
        bus_read(uart_pkg::addr_data, rd);
        check_value("rdata data", rd, b1);
        bus_read(uart_pkg::addr_status, rd);
        check_value("status rx_valid", {7'd0, rd[uart_pkg::status_rx_valid]}, 8'h00);
        wait_status(uart_pkg::status_tx_busy, 1'b0);
        loopback = 1'b0;
        b1 = 8'($random(seed));
        b2 = 8'($random(seed));
        send_frame(b1);
        send_frame(b2);  // no read in between
        repeat (2) @(negedge clk);
        bus_read(uart_pkg::addr_status, rd);
        check_value("status", rd, 8'((1 << uart_pkg::status_rx_valid) |
                                     (1 << uart_pkg::status_overrun)));
        bus_read(uart_pkg::addr_data, rd);
        check_value("rdata data", rd, b2);
        bus_read(uart_pkg::addr_status, rd);
        check_value("status", rd, 8'h00);
        loopback = 1'b1;
        bus_write(uart_pkg::addr_divisor, 8'd6);
        bus_read(uart_pkg::addr_divisor, rd);
        check_value("divisor", rd, 8'd6);
        bit_cycles = 6;
        b1 = 8'($random(seed));
        bus_write(uart_pkg::addr_data, b1);
        exp_q.push_back(b1);
        wait_status(uart_pkg::status_rx_valid, 1'b1);
        bus_read(uart_pkg::addr_data, rd);
        check_value("rdata data", rd, b1);
        wait_status(uart_pkg::status_tx_busy, 1'b0);
        bus_write(uart_pkg::addr_divisor, 8'd2);  // below floor
        bus_read(uart_pkg::addr_divisor, rd);
        check_value("divisor", rd, uart_pkg::min_divisor);
        check_value("frames seen", 8'(frames_seen), 8'd3);
        check_value("frames pending", 8'(exp_q.size()), 8'd0);
        if (dut0.uart0.checker0.fail_count != 0) begin
            stop_run("assertion failed in the uart core");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

    initial begin : tx_monitor
        logic [7:0] frame;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (tx === 1'b0) begin
                repeat (bit_cycles / 2) @(negedge clk);  // mid start bit
                check_value("tx start bit", {7'd0, tx}, 8'h00);
                for (int i = 0; i < uart_pkg::data_bits; i++) begin
                    repeat (bit_cycles) @(negedge clk);
                    frame[i] = tx;
                end
                repeat (bit_cycles) @(negedge clk);
                check_value("tx stop bit", {7'd0, tx}, 8'h01);
                if (exp_q.size() == 0) stop_run("frame on tx with no byte written");
                check_value("tx byte", frame, exp_q.pop_front());
                frames_seen++;
            end
        end
    end

    always begin
        @(negedge clk);
        #1;  // after drive settles
        if (rst_n) begin
            check_value("led_r", {7'd0, led_r}, {7'd0, !tx});
            check_value("led_g", {7'd0, led_g}, {7'd0, !rx});
        end
        if (run_seen) check_value("led_b", {7'd0, led_b}, 8'h01);
        if (dut0.uart0.checker0.fail_count != 0) stop_run("assertion failed in the uart core");
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        stop_run("watchdog timeout, the test did not finish");
    end

endmodule

//--- verif/uart_checker.sv
// UART core assertions
// tx idle level, start bit timing, read data stability and rx_valid source

`timescale 1ns/1ns

module uart_checker (
    input logic       clk,
    input logic       rst_n,
    input logic       tx,
    input logic       tx_busy,
    input logic       tx_start,
    input logic       en,
    input logic       wr,
    input logic [7:0] rdata,
    input logic       rx_done,
    input logic       rx_valid
);

    int fail_count = 0;  // watched from the testbench top

    tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> tx)
        else begin
            fail_count++;
            $error("tx low while tx_busy is clear");
        end

    tx_start_bit: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |=> (!tx && tx_busy))  // start bit right after accept
        else begin
            fail_count++;
            $error("tx did not go low one cycle after tx_start");
        end

    rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(rdata) |-> $past(en && !wr))
        else begin
            fail_count++;
            $error("rdata changed without a read in the previous cycle");
        end

    rx_valid_src: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rx_valid) |-> $past(rx_done))  // only a received byte sets it
        else begin
            fail_count++;
            $error("rx_valid rose without rx_done");
        end

endmodule

bind uart uart_checker checker0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_start (tx_start),
    .en       (en),
    .wr       (wr),
    .rdata    (rdata),
    .rx_done  (rx_done),
    .rx_valid (regs0.rx_valid)
);
